//--- hw/ifu_align_queue.sv
// ----------------------------------------------------------
// Response classification, halfword queue and
// instruction assembly for the decode stage
// ----------------------------------------------------------

module ifu_align_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ifu_pkg::new_pc_s              new_pc,
    input  logic                          stop_fetch,
    input  ifu_pkg::resp_evt_s            resp_evt,
    input  ifu_pkg::imem_word_u           rdata,
    input  logic                          idu_rdy,
    output ifu_pkg::idu_out_s             idu,
    output logic [ifu_pkg::q_free_w-1:0]  q_free_words
);

    typedef logic [ifu_pkg::q_ptr_w-1:0]  ptr_t;
    typedef logic [ifu_pkg::q_ptr_w-2:0]  adr_t;
    typedef logic [ifu_pkg::xlen/2-1:0]   half_t;

    logic  flush;
    logic  resp_vd;
    logic  unaligned;        // Next kept word starts at its upper half
    logic  we_hi;
    logic  we_full;
    logic  re_half;
    logic  re_word;
    logic  q_empty;
    ptr_t  rptr;
    ptr_t  wptr;
    ptr_t  rptr_next;
    ptr_t  wptr_next;
    ptr_t  wptr_inc;
    ptr_t  rptr_inc;
    ptr_t  ocpd;
    ptr_t  free_h;
    half_t q_data [ifu_pkg::q_size_half];
    logic  q_err  [ifu_pkg::q_size_half];
    half_t head_data;
    half_t next_data;
    logic  head_err;
    logic  next_err;
    logic  head_rvi;

    assign flush   = new_pc.req | stop_fetch;
    assign resp_vd = resp_evt.ok | resp_evt.er;

    // ------------------------------------------------------------
    // Classification of kept words
    // ------------------------------------------------------------
    // Unaligned start skips the lower half; a fault stores the whole word
    assign we_hi   = resp_evt.ok & unaligned;
    assign we_full = resp_evt.er | (resp_evt.ok & ~unaligned);

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            unaligned <= 1'b0;
        end else if (new_pc.req) begin
            unaligned <= new_pc.pc[1];
        end else if (resp_vd) begin
            unaligned <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Halfword queue
    // ------------------------------------------------------------
    assign q_empty   = (rptr == wptr);
    assign ocpd      = wptr - rptr;
    assign wptr_inc  = wptr + 1'b1;
    assign rptr_inc  = rptr + 1'b1;
    assign wptr_next = wptr + (we_full ? ptr_t'(2) : ptr_t'(we_hi));
    assign rptr_next = rptr + (re_word ? ptr_t'(2) : ptr_t'(re_half));

    // Free space seen by the request logic, after this cycle's read
    assign free_h       = ptr_t'(ifu_pkg::q_size_half) - (wptr - rptr_next);
    assign q_free_words = free_h[ifu_pkg::q_ptr_w-1:1];

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;
            wptr <= '0;
        end else begin
            rptr <= rptr_next;
            wptr <= wptr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (~flush) begin
            if (we_full) begin
                q_data[adr_t'(wptr)]     <= rdata.half.lo;
                q_err[adr_t'(wptr)]      <= resp_evt.er;
                q_data[adr_t'(wptr_inc)] <= rdata.half.hi;
                q_err[adr_t'(wptr_inc)]  <= resp_evt.er;
            end else if (we_hi) begin
                q_data[adr_t'(wptr)]     <= rdata.half.hi;
                q_err[adr_t'(wptr)]      <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Decode side
    // ------------------------------------------------------------
    assign head_data = q_data[adr_t'(rptr)];
    assign next_data = q_data[adr_t'(rptr_inc)];
    assign head_err  = q_err[adr_t'(rptr)];
    assign next_err  = q_err[adr_t'(rptr_inc)];
    assign head_rvi  = &head_data[1:0];

    // A faulty head leaves as a single halfword
    assign re_half = idu.vd & idu_rdy & (~head_rvi | head_err);
    assign re_word = idu.vd & idu_rdy & head_rvi & ~head_err;

    always_comb begin
        idu       = '0;
        idu.instr = head_rvi ? {next_data, head_data}
                             : {{(ifu_pkg::xlen/2){1'b0}}, head_data};
        if (~q_empty) begin
            if (ocpd == ptr_t'(1)) begin
                idu.vd       = ~head_rvi | head_err;   // Lone RVI half waits
                idu.imem_err = head_err;
            end else begin
                idu.vd         = 1'b1;
                idu.imem_err   = head_err | (head_rvi & next_err);
                idu.err_rvi_hi = ~head_err & head_rvi & next_err;
            end
        end
    end

endmodule

//--- hw/ifu_fetch_fsm.sv
// ----------------------------------------------------------
// Fetch state machine, fetch address register and
// instruction memory request generation
// ----------------------------------------------------------

module ifu_fetch_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ifu_pkg::new_pc_s               new_pc,
    input  logic                           stop_fetch,
    input  logic                           imem_req_ack,
    input  ifu_pkg::resp_evt_s             resp_evt,
    input  logic                           txn_full,
    input  logic [ifu_pkg::txn_cnt_w-1:0]  vd_pending,
    input  logic [ifu_pkg::q_free_w-1:0]   q_free_words,
    output ifu_pkg::imem_req_s             imem,
    output logic                           txn_issue,
    output logic                           ifu_busy
);

    typedef logic [ifu_pkg::txn_cnt_w-1:0] cnt_t;
    typedef logic [ifu_pkg::xlen-1:2]      waddr_t;

    ifu_pkg::fsm_state_e state;
    waddr_t              addr_r;     // Next word to fetch
    waddr_t              addr_base;
    logic                room;

    // ------------------------------------------------------------
    // Request generation
    // ------------------------------------------------------------
    // Only ask when the queue can still take every word in flight
    assign room = cnt_t'(q_free_words) > vd_pending;

    assign addr_base = new_pc.req ? new_pc.pc[ifu_pkg::xlen-1:2] : addr_r;

    assign imem.req  = (new_pc.req & ~txn_full & ~stop_fetch)
                     | ((state == ifu_pkg::fsm_fetch) & ~txn_full & room);
    assign imem.addr = {addr_base, 2'b00};

    assign txn_issue = imem.req & imem_req_ack;

    always_ff @(posedge clk) begin
        if (txn_issue) begin
            addr_r <= addr_base + 1'b1;                     // Step past the accepted word
        end else if (new_pc.req) begin
            addr_r <= new_pc.pc[ifu_pkg::xlen-1:2];         // Hold target until accepted
        end
    end

    // ------------------------------------------------------------
    // Idle / fetch control
    // ------------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            state <= ifu_pkg::fsm_idle;
        end else begin
            case (state)
                ifu_pkg::fsm_idle: begin
                    if (new_pc.req & ~stop_fetch) begin
                        state <= ifu_pkg::fsm_fetch;
                    end
                end
                ifu_pkg::fsm_fetch: begin
                    // A kept error ends the stream unless a redirect arrives with it
                    if (stop_fetch | (resp_evt.er & ~new_pc.req)) begin
                        state <= ifu_pkg::fsm_idle;
                    end
                end
                default: begin
                    state <= ifu_pkg::fsm_idle;
                end
            endcase
        end
    end

    assign ifu_busy = (state == ifu_pkg::fsm_fetch);

endmodule

//--- hw/ifu_pkg.sv
// ----------------------------------------------------------
// Instruction fetch unit sizes, enums and bus structs
// Memory word union with RVI and halfword views
// ----------------------------------------------------------

package ifu_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int xlen        = 32;
    localparam int txn_cnt_w   = 3;                            // Up to 7 reads in flight
    localparam int q_size_half = 4;                            // Queue depth in halfwords
    localparam int q_ptr_w     = $clog2(q_size_half) + 1;      // Extra wrap bit
    localparam int q_free_w    = $clog2(q_size_half / 2 + 1);  // Free words 0..2

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    typedef enum logic {
        fsm_idle,
        fsm_fetch
    } fsm_state_e;

    typedef enum logic [1:0] {
        mem_resp_notrdy,
        mem_resp_rdy_ok,
        mem_resp_rdy_er
    } mem_resp_e;

    // One memory word, seen as a whole RVI or as two halfwords
    typedef union packed {
        logic [xlen-1:0] rvi;
        struct packed {
            logic [xlen/2-1:0] hi;
            logic [xlen/2-1:0] lo;
        } half;
    } imem_word_u;

    // ------------------------------------------------------------
    // Bus bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic            req;
        logic [xlen-1:0] addr;   // Always word aligned
    } imem_req_s;

    typedef struct packed {
        mem_resp_e  resp;
        imem_word_u rdata;
    } imem_rsp_s;

    typedef struct packed {
        logic            req;
        logic [xlen-1:0] pc;     // Halfword aligned target
    } new_pc_s;

    typedef struct packed {
        logic ok;
        logic er;
    } resp_evt_s;

    typedef struct packed {
        logic            vd;
        logic            imem_err;
        logic            err_rvi_hi;  // Fault only on the upper RVI half
        logic [xlen-1:0] instr;
    } idu_out_s;

endpackage

//--- hw/ifu_top.sv
// ----------------------------------------------------------
// Instruction fetch unit top level
// ----------------------------------------------------------

module ifu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ifu_pkg::new_pc_s     new_pc,
    input  logic                 stop_fetch,
    input  logic                 imem_req_ack,
    input  ifu_pkg::imem_rsp_s   imem_rsp,
    output ifu_pkg::imem_req_s   imem,
    input  logic                 idu_rdy,
    output ifu_pkg::idu_out_s    idu,
    output logic                 ifu_busy
);

    logic                          txn_issue;
    logic                          txn_full;
    logic [ifu_pkg::txn_cnt_w-1:0] vd_pending;
    logic [ifu_pkg::q_free_w-1:0]  q_free_words;
    ifu_pkg::resp_evt_s            resp_evt;

    ifu_fetch_fsm u_fetch_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req_ack (imem_req_ack),
        .resp_evt     (resp_evt),
        .txn_full     (txn_full),
        .vd_pending   (vd_pending),
        .q_free_words (q_free_words),
        .imem         (imem),
        .txn_issue    (txn_issue),
        .ifu_busy     (ifu_busy)
    );

    ifu_txn_counter u_txn_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_pc_req (new_pc.req),
        .txn_issue  (txn_issue),
        .imem_resp  (imem_rsp.resp),
        .resp_evt   (resp_evt),
        .vd_pending (vd_pending),
        .txn_full   (txn_full)
    );

    ifu_align_queue u_align_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .resp_evt     (resp_evt),
        .rdata        (imem_rsp.rdata),
        .idu_rdy      (idu_rdy),
        .idu          (idu),
        .q_free_words (q_free_words)
    );

endmodule

//--- hw/ifu_txn_counter.sv
// ----------------------------------------------------------
// Outstanding read counter, discard counter and
// response filter
// ----------------------------------------------------------

module ifu_txn_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           new_pc_req,
    input  logic                           txn_issue,
    input  ifu_pkg::mem_resp_e             imem_resp,
    output ifu_pkg::resp_evt_s             resp_evt,
    output logic [ifu_pkg::txn_cnt_w-1:0]  vd_pending,
    output logic                           txn_full
);

    typedef logic [ifu_pkg::txn_cnt_w-1:0] cnt_t;

    cnt_t pend;          // Reads sent, not yet answered
    cnt_t pend_new;
    cnt_t disc_cnt;      // Answers still to be dropped
    cnt_t disc_new;
    logic rsp_ok;
    logic rsp_er;
    logic rsp_any;
    logic discard;

    assign rsp_ok  = (imem_resp == ifu_pkg::mem_resp_rdy_ok);
    assign rsp_er  = (imem_resp == ifu_pkg::mem_resp_rdy_er);
    assign rsp_any = rsp_ok | rsp_er;
    assign discard = |disc_cnt;

    // ------------------------------------------------------------
    // Pending reads
    // ------------------------------------------------------------
    assign pend_new = pend + cnt_t'(txn_issue) - cnt_t'(rsp_any);

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            pend <= '0;
        end else if (txn_issue ^ rsp_any) begin
            pend <= pend_new;
        end
    end

    assign txn_full = &pend;

    // ------------------------------------------------------------
    // Discard count
    // ------------------------------------------------------------
    always_comb begin
        if (new_pc_req) begin
            disc_new = pend_new - cnt_t'(txn_issue);   // A read issued now is for the new PC
        end else if (rsp_er & ~discard) begin
            disc_new = pend_new;                       // Drop everything after a fault
        end else begin
            disc_new = disc_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            disc_cnt <= '0;
        end else if (new_pc_req | (rsp_er & ~discard) | (rsp_any & discard)) begin
            disc_cnt <= disc_new;
        end
    end

    assign vd_pending  = pend - disc_cnt;
    assign resp_evt.ok = rsp_ok & ~discard;
    assign resp_evt.er = rsp_er & ~discard;

endmodule

//--- list.f
hw/ifu_pkg.sv
hw/ifu_fetch_fsm.sv
hw/ifu_txn_counter.sv
hw/ifu_align_queue.sv
hw/ifu_top.sv
tests/tb_clk_gen.sv
tests/tb_ifu.sv

//--- tests/tb_clk_gen.sv
// ----------------------------------------------------------
// Testbench clock and reset generator
// ----------------------------------------------------------

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 10;   // 20 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                   // Release away from the active edge
    end

endmodule

//--- tests/tb_ifu.sv
// ----------------------------------------------------------
// Instruction fetch unit testbench with a test table,
// in-order memory model, compare tasks and result report
// ----------------------------------------------------------

module tb_ifu;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] start_pc;
        logic        has_err;
        logic [31:0] err_addr;
        logic [31:0] redir_pc;     // Zero when no mid-stream redirect
        logic        bp;           // Random back-pressure and ack gaps
        logic [7:0]  n_instr;
    } test_row_s;

    localparam int num_tests     = 8;
    localparam int wait_limit    = 400;
    localparam int redir_after   = 5;
    localparam int settle_cycles = 16;

    localparam test_row_s test_table [num_tests] = '{
        // start_pc    err   err_addr       redir_pc       bp    count
        '{32'h0000_1000, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'd12},  // RVI only
        '{32'h0000_0100, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'd24},  // Mixed
        '{32'h0000_0202, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'd12},  // Upper half start
        '{32'h0000_0300, 1'b1, 32'h0000_0304, 32'h0000_0000, 1'b0, 8'd16},  // Fault on RVI hi
        '{32'h0000_0400, 1'b1, 32'h0000_0408, 32'h0000_0000, 1'b0, 8'd16},  // Fault on RVI lo
        '{32'h0000_0500, 1'b0, 32'h0000_0000, 32'h0000_0a06, 1'b0, 8'd16},
        '{32'h0000_0700, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'd40},
        '{32'h0000_1100, 1'b0, 32'h0000_0000, 32'h0000_0812, 1'b1, 8'd24}
    };

    logic                clk;
    logic                rst_n;
    ifu_pkg::new_pc_s    new_pc;
    logic                stop_fetch;
    logic                imem_req_ack;
    ifu_pkg::imem_rsp_s  imem_rsp;
    ifu_pkg::imem_req_s  imem;
    logic                idu_rdy;
    ifu_pkg::idu_out_s   idu;
    logic                ifu_busy;

    int                  seed = 44;
    int                  cycle;
    int                  errors;
    int                  checks;
    logic                timed_out;
    logic                err_on;
    logic                bp_on;
    logic [31:0]         err_word;
    logic                busy_seen;
    logic [31:0]         rd_addr_q [$];    // Accepted reads, oldest first
    int                  rd_due_q  [$];
    int                  last_due;
    logic [31:0]         rsp_addr;
    int                  due;
    ifu_pkg::idu_out_s   obs_q [$];        // Instructions taken by decode
    ifu_pkg::idu_out_s   exp_q [$];

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ifu_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req_ack (imem_req_ack),
        .imem_rsp     (imem_rsp),
        .imem         (imem),
        .idu_rdy      (idu_rdy),
        .idu          (idu),
        .ifu_busy     (ifu_busy)
    );

    // ----------------------------------------------------------
    // Memory contents
    // ----------------------------------------------------------
    // Low bits follow an 8-halfword pattern with straddling RVI
    function automatic logic [15:0] half_at(input logic [31:0] a);
        logic [31:0] mix;
        logic [1:0]  kind;
        mix = ({a[31:1], 1'b0} * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
        case (a[3:1])
            3'd0:    kind = 2'b10;        // RVC
            3'd1:    kind = 2'b11;        // RVI into next word
            3'd2:    kind = 2'b00;
            3'd3:    kind = 2'b01;        // RVC
            3'd4:    kind = 2'b11;        // Aligned RVI
            3'd5:    kind = 2'b11;
            3'd6:    kind = 2'b00;        // RVC
            default: kind = 2'b11;        // RVI into next period
        endcase
        if (a[12] && !a[1]) begin
            kind = 2'b11;                 // Region of whole-word RVI only
        end
        return {mix[31:18], kind};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {half_at({a[31:2], 2'b10}), half_at({a[31:2], 2'b00})};
    endfunction

    // Halfword walk from pc, ends on the first instruction touching a fault
    task automatic build_expected(input logic [31:0] pc, input int count,
                                  input logic with_err, input logic [31:0] err_addr);
        ifu_pkg::idu_out_s e;
        logic [31:0]       a;
        logic [31:0]       a_hi;
        logic [15:0]       h0;
        logic              hit_lo;
        logic              hit_hi;
        int                i;
        exp_q.delete();
        a = pc;
        for (i = 0; i < count; i++) begin
            h0       = half_at(a);
            e        = '0;
            e.vd     = 1'b1;
            hit_lo   = with_err && (a[31:2] == err_addr[31:2]);
            if (h0[1:0] == 2'b11) begin
                a_hi         = a + 32'd2;
                hit_hi       = with_err && (a_hi[31:2] == err_addr[31:2]);
                e.instr      = {half_at(a_hi), h0};
                e.imem_err   = hit_lo | hit_hi;
                e.err_rvi_hi = !hit_lo && hit_hi;
                a            = a + 32'd4;
            end else begin
                e.instr    = {16'h0000, h0};
                e.imem_err = hit_lo;
                a          = a + 32'd2;
            end
            exp_q.push_back(e);
            if (e.imem_err) begin
                break;
            end
        end
    endtask

    // ----------------------------------------------------------
    // Memory model and decode monitor
    // ----------------------------------------------------------
    initial begin
        imem_req_ack = 1'b1;
        idu_rdy      = 1'b1;
        imem_rsp     = '0;
        cycle        = 0;
        last_due     = 0;
        busy_seen    = 1'b0;
        forever begin
            @(negedge clk);
            cycle++;
            if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
                rsp_addr       = rd_addr_q.pop_front();
                void'(rd_due_q.pop_front());
                imem_rsp.rdata = mem_word(rsp_addr);
                if (err_on && rsp_addr[31:2] == err_word[31:2]) begin
                    imem_rsp.resp = ifu_pkg::mem_resp_rdy_er;
                end else begin
                    imem_rsp.resp = ifu_pkg::mem_resp_rdy_ok;
                end
            end else begin
                imem_rsp.resp  = ifu_pkg::mem_resp_notrdy;
                imem_rsp.rdata = '0;
            end
            imem_req_ack = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
            idu_rdy      = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
            #8;                                             // Sample just before the edge
            if (rst_n && imem.req && imem_req_ack) begin
                due = cycle + 1 + int'($unsigned($random(seed)) % 3);
                if (due <= last_due) begin
                    due = last_due + 1;                     // Keep answers in order
                end
                last_due = due;
                rd_addr_q.push_back(imem.addr);
                rd_due_q.push_back(due);
            end
            if (idu.vd && idu_rdy) begin
                obs_q.push_back(idu);
            end
            busy_seen = ifu_busy;
        end
    end

    // ----------------------------------------------------------
    // Compare tasks and bounded waits
    // ----------------------------------------------------------
    task automatic check_instr(input int idx, input ifu_pkg::idu_out_s got,
                               input ifu_pkg::idu_out_s exp);
        logic bad;
        checks++;
        if (exp.imem_err) begin
            bad = (got.imem_err !== 1'b1) || (got.err_rvi_hi !== exp.err_rvi_hi);
        end else begin
            bad = (got !== exp);
        end
        if (bad) begin
            errors++;
            $display("Error at %0d ns: instruction %0d is %h err %b/%b, expected %h err %b/%b",
                     $time, idx, got.instr, got.imem_err, got.err_rvi_hi,
                     exp.instr, exp.imem_err, exp.err_rvi_hi);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: ifu_busy is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic wait_obs(input int count);
        int k;
        k = 0;
        while (obs_q.size() < count && k < wait_limit) begin
            @(negedge clk);
            k++;
        end
        if (obs_q.size() < count) begin
            timed_out = 1'b1;
            $display("Timeout at %0d ns: only %0d of %0d instructions reached decode",
                     $time, obs_q.size(), count);
        end
    endtask

    task automatic wait_mem_idle();
        int k;
        k = 0;
        while (rd_addr_q.size() != 0 && k < wait_limit) begin
            @(negedge clk);
            k++;
        end
        if (rd_addr_q.size() != 0) begin
            timed_out = 1'b1;
            $display("Timeout at %0d ns: memory reads still outstanding", $time);
        end
    endtask

    task automatic wait_reset();
        int k;
        k = 0;
        while (!rst_n && k < wait_limit) begin
            @(negedge clk);
            k++;
        end
        if (!rst_n) begin
            timed_out = 1'b1;
            $display("Timeout at %0d ns: reset was never released", $time);
        end
    endtask

    // One-cycle new-PC request, returns on the following falling edge
    task automatic drive_redirect(input logic [31:0] pc);
        new_pc.req = 1'b1;
        new_pc.pc  = pc;
        @(negedge clk);
        new_pc.req = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Test rows
    // ----------------------------------------------------------
    task automatic run_test(input int t);
        test_row_s         row;
        ifu_pkg::idu_out_s fault_exp;
        int                errs_before;
        int                n_wait;
        int                n_seen;
        int                extras;
        int                i;
        row         = test_table[t];
        errs_before = errors;
        err_on      = row.has_err;
        err_word    = row.err_addr;
        bp_on       = row.bp;
        build_expected(row.start_pc, int'(row.n_instr) + 24, row.has_err, row.err_addr);
        drive_redirect(row.start_pc);
        obs_q.delete();                                     // Drop leftovers of the last row
        if (row.redir_pc != '0) begin
            wait_obs(redir_after);
            if (timed_out) begin
                return;
            end
            drive_redirect(row.redir_pc);
            for (i = 0; i < obs_q.size() && i < exp_q.size(); i++) begin
                check_instr(i, obs_q[i], exp_q[i]);        // Old stream up to the flush
            end
            obs_q.delete();
            build_expected(row.redir_pc, int'(row.n_instr) + 24, 1'b0, '0);
        end
        n_wait = row.has_err ? exp_q.size() : int'(row.n_instr);
        wait_obs(n_wait);
        if (timed_out) begin
            return;
        end
        repeat (settle_cycles) @(negedge clk);
        fault_exp          = '0;
        fault_exp.vd       = 1'b1;
        fault_exp.imem_err = 1'b1;
        extras             = 0;
        n_seen             = obs_q.size();
        for (i = 0; i < n_seen; i++) begin
            if (i < exp_q.size()) begin
                check_instr(i, obs_q[i], exp_q[i]);
            end else if (row.has_err) begin
                check_instr(i, obs_q[i], fault_exp);       // Rest of the faulting word only
                extras++;
            end
        end
        if (extras > 1) begin
            errors++;
            $display("Test %0d: %0d halfwords were handed over after the fault", t, extras);
        end
        check_busy(busy_seen, !row.has_err);
        // Stop fetching and let the memory drain
        err_on     = 1'b0;
        bp_on      = 1'b0;
        stop_fetch = 1'b1;
        @(negedge clk);
        stop_fetch = 1'b0;
        wait_mem_idle();
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        check_busy(ifu_busy, 1'b0);
        $display("Test %0d from pc %h: %0d instructions, %s", t, row.start_pc, n_seen,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        new_pc     = '0;
        stop_fetch = 1'b0;
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        err_on     = 1'b0;
        bp_on      = 1'b0;
        err_word   = '0;
        wait_reset();
        if (!timed_out) begin
            @(negedge clk);
            check_busy(ifu_busy, 1'b0);
        end
        for (int t = 0; t < num_tests && !timed_out; t++) begin
            run_test(t);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
